// ==== design/if_cfg_pkg.sv ====
// Fetch stage configuration
// Address and word widths, trap vector layout and default buffer depth
`default_nettype none

package if_cfg_pkg;

  // Width of addresses and instruction words
  parameter int unsigned addr_width = 32;

  // mtvec base holds the address bits above bit 6
  parameter int unsigned mtvec_width = 25;

  // Interrupt index used for vectored traps
  parameter int unsigned irq_id_width = 5;

  // Zero bits appended below the mtvec base
  parameter int unsigned mtvec_align_bits = addr_width - mtvec_width;

  // Vector table entries are one word apart
  parameter int unsigned vector_shift = 2;

  // Default depth of the instruction buffer and the outstanding queue
  parameter int unsigned fifo_depth_default = 4;

endpackage

`default_nettype wire

// ==== design/if_types_pkg.sv ====
// Fetch stage types
// Next-PC source encoding and the records that move between fetch blocks
`default_nettype none

package if_types_pkg;

  ////////////////////////////////////////////////////////////
  // Next-PC source select
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5,
    PC_TRAP_DBD = 3'd6
  } pc_mux_e;

  ////////////////////////////////////////////////////////////
  // Fetch records
  ////////////////////////////////////////////////////////////

  // One fetched word with its address and bus error flag
  typedef struct packed {
    logic [if_cfg_pkg::addr_width-1:0] pc;
    logic [if_cfg_pkg::addr_width-1:0] word;
    logic                              err;
  } fetch_entry_t;

  // One granted request still waiting for its response
  typedef struct packed {
    logic [if_cfg_pkg::addr_width-1:0] addr;
    // Response belongs to a fetch stream that was redirected
    logic                              stale;
  } out_req_t;

endpackage

`default_nettype wire

// ==== design/fetch_out_if.sv ====
// Buffered instruction channel
// Prefetcher offers the buffer head, the IF/ID register pops it
`timescale 1ns/1ps
`default_nettype none

interface fetch_out_if;

  // Buffer holds at least one word
  logic                       valid;
  // Buffer head
  if_types_pkg::fetch_entry_t entry;
  // Head consumed this cycle, only while valid
  logic                       pop;

  modport source (
    output valid,
    output entry,
    input  pop
  );

  modport sink (
    input  valid,
    input  entry,
    output pop
  );

endinterface

`default_nettype wire

// ==== design/fetch_fifo.sv ====
// Small synchronous FIFO
// Circular buffer with fill count and single-cycle flush, generic payload
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo #(
  parameter int unsigned FIFO_DEPTH = if_cfg_pkg::fifo_depth_default,
  parameter type         payload_t  = logic [31:0]
) (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              flush_i,
  input  wire logic                              push_i,
  input  wire payload_t                          push_data_i,
  input  wire logic                              pop_i,
  output payload_t                               head_o,
  output logic                                   empty_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]        count_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  // Storage
  payload_t         mem [FIFO_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;

  // Pointer increment with wrap at the last slot
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      // Flush wins over push and pop in the same cycle
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Fill count only moves when exactly one side is active
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  assign head_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign count_o = count;

endmodule

`default_nettype wire

// ==== design/pc_mux.sv ====
// Next-PC selection
// Picks the fetch target by source and flags mtvec init on boot
// Purely combinational
`timescale 1ns/1ps
`default_nettype none

module pc_mux (
  input  wire if_types_pkg::pc_mux_e                   pc_mux_i,
  input  wire logic                                    pc_set_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]       boot_addr_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]       jump_target_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]       branch_target_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]       mepc_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]       dm_halt_addr_i,
  input  wire logic [if_cfg_pkg::mtvec_width-1:0]      mtvec_addr_i,
  input  wire logic [if_cfg_pkg::irq_id_width-1:0]     irq_id_i,
  output logic [if_cfg_pkg::addr_width-1:0]            branch_addr_o,
  output logic                                         csr_mtvec_init_o
);

  localparam int unsigned AW = if_cfg_pkg::addr_width;

  logic [AW-1:0] trap_base;
  logic [AW-1:0] irq_offset;

  // Exception target is the mtvec base itself
  assign trap_base  = {mtvec_addr_i, {if_cfg_pkg::mtvec_align_bits{1'b0}}};
  // One word per interrupt index
  assign irq_offset = AW'(irq_id_i) << if_cfg_pkg::vector_shift;

  always_comb begin
    // Boot target unless a source says otherwise
    branch_addr_o = {boot_addr_i[AW-1:2], 2'b00};
    unique case (pc_mux_i)
      if_types_pkg::PC_BOOT:     branch_addr_o = {boot_addr_i[AW-1:2], 2'b00};
      if_types_pkg::PC_JUMP:     branch_addr_o = jump_target_i;
      if_types_pkg::PC_BRANCH:   branch_addr_o = branch_target_i;
      // Return from trap
      if_types_pkg::PC_MRET:     branch_addr_o = mepc_i;
      if_types_pkg::PC_TRAP_EXC: branch_addr_o = trap_base;
      // Vectored interrupt entry
      if_types_pkg::PC_TRAP_IRQ: branch_addr_o = trap_base + irq_offset;
      if_types_pkg::PC_TRAP_DBD: branch_addr_o = {dm_halt_addr_i[AW-1:2], 2'b00};
      default:                   branch_addr_o = {boot_addr_i[AW-1:2], 2'b00};
    endcase
  end

  // CSR file loads its mtvec reset value on boot
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == if_types_pkg::PC_BOOT);

endmodule

`default_nettype wire

// ==== design/prefetch_unit.sv ====
// Instruction prefetcher
// Issues word fetches on the request/grant bus, queues granted addresses,
// drops responses of redirected streams and buffers the rest
`timescale 1ns/1ps
`default_nettype none

module prefetch_unit #(
  parameter int unsigned FIFO_DEPTH = if_cfg_pkg::fifo_depth_default
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                pc_set_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]   branch_addr_i,
  output logic                                     instr_req_o,
  output logic [if_cfg_pkg::addr_width-1:0]        instr_addr_o,
  input  wire logic                                instr_gnt_i,
  input  wire logic                                instr_rvalid_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]   instr_rdata_i,
  input  wire logic                                instr_err_i,
  output logic                                     busy_o,
  fetch_out_if.source                              fetch
);

  localparam int unsigned AW    = if_cfg_pkg::addr_width;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic                       fetch_en;
  logic [AW-1:0]              req_addr;
  // Redirect that arrived while a request waited for its grant
  logic                       redir_pend;
  logic [AW-1:0]              redir_addr;
  // Responses still owed to streams older than the last redirect
  logic [CNT_W-1:0]           drop_cnt;

  logic                       space_ok;
  logic                       req_accept;
  logic                       rsp_drop;

  if_types_pkg::out_req_t     out_push_data;
  if_types_pkg::out_req_t     out_head;
  logic                       out_empty;
  logic [CNT_W-1:0]           out_cnt;

  if_types_pkg::fetch_entry_t buf_push_data;
  logic                       buf_empty;
  logic [CNT_W-1:0]           buf_cnt;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Slots left once all outstanding words have landed in the buffer
  assign space_ok    = (int'(out_cnt) + int'(buf_cnt)) < FIFO_DEPTH;
  assign instr_req_o = fetch_en && space_ok;
  assign req_accept  = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en   <= 1'b0;
      req_addr   <= '0;
      redir_pend <= 1'b0;
      redir_addr <= '0;
    end else if (pc_set_i) begin
      fetch_en <= 1'b1;
      if (instr_req_o && !instr_gnt_i) begin
        // Bus address must stay put until granted
        redir_pend <= 1'b1;
        redir_addr <= branch_addr_i;
      end else begin
        redir_pend <= 1'b0;
        req_addr   <= branch_addr_i;
      end
    end else if (req_accept) begin
      if (redir_pend) begin
        redir_pend <= 1'b0;
        req_addr   <= redir_addr;
      end else begin
        // Sequential fetch
        req_addr <= req_addr + AW'(4);
      end
    end
  end

  assign instr_addr_o = req_addr;

  // Grant in a redirect cycle, or of a held old request, is stale
  assign out_push_data.addr  = req_addr;
  assign out_push_data.stale = pc_set_i || redir_pend;

  ////////////////////////////////////////////////////////////
  // Outstanding requests
  ////////////////////////////////////////////////////////////

  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .payload_t  (if_types_pkg::out_req_t)
  ) i_out_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (1'b0),
    .push_i      (req_accept),
    .push_data_i (out_push_data),
    .pop_i       (instr_rvalid_i),
    .head_o      (out_head),
    .empty_o     (out_empty),
    .count_o     (out_cnt)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else if (pc_set_i) begin
      // Everything queued before this cycle is now stale
      drop_cnt <= out_cnt - CNT_W'(instr_rvalid_i);
    end else if (instr_rvalid_i && (drop_cnt != '0)) begin
      drop_cnt <= drop_cnt - 1'b1;
    end
  end

  assign rsp_drop = (drop_cnt != '0) || out_head.stale;

  ////////////////////////////////////////////////////////////
  // Instruction buffer
  ////////////////////////////////////////////////////////////

  assign buf_push_data.pc   = out_head.addr;
  assign buf_push_data.word = instr_rdata_i;
  assign buf_push_data.err  = instr_err_i;

  // Redirect flushes the buffer, flush wins over a same-cycle push
  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .payload_t  (if_types_pkg::fetch_entry_t)
  ) i_buf_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (pc_set_i),
    .push_i      (instr_rvalid_i && !rsp_drop),
    .push_data_i (buf_push_data),
    .pop_i       (fetch.pop),
    .head_o      (fetch.entry),
    .empty_o     (buf_empty),
    .count_o     (buf_cnt)
  );

  // Old stream words are hidden in the redirect cycle
  assign fetch.valid = !buf_empty && !pc_set_i;

  assign busy_o = !out_empty;

endmodule

`default_nettype wire

// ==== design/if_id_register.sv ====
// IF/ID pipeline register
// Valid/ready handshake toward decode, kill and halt masking,
// registered instruction for the decode stage
`timescale 1ns/1ps
`default_nettype none

module if_id_register (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                kill_if_i,
  input  wire logic                                halt_if_i,
  input  wire logic                                id_ready_i,
  fetch_out_if.sink                                fetch,
  output logic                                     if_valid_o,
  output logic                                     id_valid_o,
  output logic [if_cfg_pkg::addr_width-1:0]        id_pc_o,
  output logic [if_cfg_pkg::addr_width-1:0]        id_instr_o,
  output logic                                     id_err_o
);

  logic if_transfer;

  // Kill and halt both hide the buffer head from decode
  assign if_valid_o  = fetch.valid && !kill_if_i && !halt_if_i;
  assign if_transfer = if_valid_o && id_ready_i;

  // Kill throws the head away, halt leaves it in place
  assign fetch.pop = fetch.valid && (kill_if_i || if_transfer);

  ////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
      id_pc_o    <= '0;
      id_instr_o <= '0;
      id_err_o   <= 1'b0;
    end else if (if_transfer) begin
      id_valid_o <= 1'b1;
      id_pc_o    <= fetch.entry.pc;
      id_instr_o <= fetch.entry.word;
      id_err_o   <= fetch.entry.err;
    end else if (id_ready_i) begin
      // Decode took the old one and nothing new came in
      id_valid_o <= 1'b0;
    end
    // Decode stalled, everything holds
  end

endmodule

`default_nettype wire

// ==== design/if_stage.sv ====
// Instruction fetch stage
// Next-PC mux, prefetcher with instruction buffer and IF/ID register
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
  parameter int unsigned FIFO_DEPTH = if_cfg_pkg::fifo_depth_default
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  // Control
  input  wire logic                                pc_set_i,
  input  wire if_types_pkg::pc_mux_e               pc_mux_i,
  input  wire logic                                kill_if_i,
  input  wire logic                                halt_if_i,
  // Target addresses
  input  wire logic [if_cfg_pkg::addr_width-1:0]   boot_addr_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]   jump_target_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]   branch_target_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]   mepc_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]   dm_halt_addr_i,
  input  wire logic [if_cfg_pkg::mtvec_width-1:0]  mtvec_addr_i,
  input  wire logic [if_cfg_pkg::irq_id_width-1:0] irq_id_i,
  // Instruction bus
  output logic                                     instr_req_o,
  output logic [if_cfg_pkg::addr_width-1:0]       instr_addr_o,
  input  wire logic                                instr_gnt_i,
  input  wire logic                                instr_rvalid_i,
  input  wire logic [if_cfg_pkg::addr_width-1:0]   instr_rdata_i,
  input  wire logic                                instr_err_i,
  // Decode side
  output logic                                     if_valid_o,
  input  wire logic                                id_ready_i,
  output logic                                     id_valid_o,
  output logic [if_cfg_pkg::addr_width-1:0]       id_pc_o,
  output logic [if_cfg_pkg::addr_width-1:0]       id_instr_o,
  output logic                                     id_err_o,
  // Status
  output logic [if_cfg_pkg::addr_width-1:0]       pc_if_o,
  output logic                                     csr_mtvec_init_o,
  output logic                                     if_busy_o
);

  logic [if_cfg_pkg::addr_width-1:0] branch_addr;

  fetch_out_if fetch_if ();

  pc_mux i_pc_mux (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_unit #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_prefetch_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (if_busy_o),
    .fetch          (fetch_if.source)
  );

  if_id_register i_if_id_register (
    .clk        (clk),
    .rst_n      (rst_n),
    .kill_if_i  (kill_if_i),
    .halt_if_i  (halt_if_i),
    .id_ready_i (id_ready_i),
    .fetch      (fetch_if.sink),
    .if_valid_o (if_valid_o),
    .id_valid_o (id_valid_o),
    .id_pc_o    (id_pc_o),
    .id_instr_o (id_instr_o),
    .id_err_o   (id_err_o)
  );

  // Address of the instruction waiting at the buffer head
  assign pc_if_o = fetch_if.entry.pc;

endmodule

`default_nettype wire

// ==== tests/tb_instr_mem.sv ====
// Instruction memory model
// Request/grant bus slave with random grant and response delays,
// in-order responses, data derived from the address, error window
`timescale 1ns/1ps
`default_nettype none

module tb_instr_mem (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        req_i,
  input  wire logic [31:0] addr_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output logic [31:0]      rdata_o,
  output logic             err_o
);

  integer      seed;
  logic        gnt_ok;
  logic [31:0] pend_q[$];
  logic [31:0] rsp_addr;
  logic [31:0] rnd;

  initial begin
    seed = 32'h93ab;
  end

  // Grant only in cycles the random draw allows
  assign gnt_o = req_i && gnt_ok;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_ok   <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      pend_q.delete();
    end else begin
      rnd = $random(seed);
      gnt_ok <= rnd[0] | rnd[1];
      // Answer only requests granted in an earlier cycle
      if ((pend_q.size() > 0) && (rnd[2] | rnd[3])) begin
        rsp_addr = pend_q.pop_front();
        rvalid_o <= 1'b1;
        rdata_o  <= rsp_addr ^ 32'h5a5a_0000;
        err_o    <= (rsp_addr >= 32'h0000_f000) && (rsp_addr <= 32'h0000_ffff);
      end else begin
        rvalid_o <= 1'b0;
      end
      if (req_i && gnt_o) begin
        pend_q.push_back(addr_i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/if_stage_sva.sv ====
// Fetch stage bus and handshake assertions
// Bound into the fetch stage top level
`timescale 1ns/1ps
`default_nettype none

module if_stage_sva (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        instr_req_o,
  input wire logic [31:0] instr_addr_o,
  input wire logic        instr_gnt_i,
  input wire logic        instr_rvalid_i,
  input wire logic        id_ready_i,
  input wire logic        id_valid_o,
  input wire logic [31:0] id_pc_o
);

  // Granted requests still waiting for a response
  logic [7:0] gnt_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_cnt <= '0;
    end else begin
      gnt_cnt <= gnt_cnt + 8'(instr_req_o && instr_gnt_i) - 8'(instr_rvalid_i);
    end
  end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("request dropped or address changed before grant");

  a_rvalid_owed: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (gnt_cnt != '0))
    else $error("response without an outstanding grant");

  a_id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable(id_valid_o) && $stable(id_pc_o))
    else $error("IF/ID register changed while decode stalled");

endmodule

bind if_stage if_stage_sva i_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .instr_req_o    (instr_req_o),
  .instr_addr_o   (instr_addr_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .id_ready_i     (id_ready_i),
  .id_valid_o     (id_valid_o),
  .id_pc_o        (id_pc_o)
);

`default_nettype wire

// ==== tests/tb_if_stage.sv ====
// Fetch stage testbench
// Applies a table of redirects, consumes instructions under decode stalls
// and halts, checks PC, word and error flag of every delivered instruction
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  typedef struct {
    if_types_pkg::pc_mux_e src;
    logic [31:0]           addr;
    logic [24:0]           mtvec;
    logic [4:0]            irq;
    int                    n_instr;
    bit                    stall;
    bit                    halt;
  } step_t;

  logic clk, rst_n, pc_set, kill_if, halt_if, id_ready;
  if_types_pkg::pc_mux_e pc_mux;
  logic [31:0] boot_addr, jump_target, branch_target, mepc, dm_halt_addr;
  logic [24:0] mtvec_addr;
  logic [4:0]  irq_id;
  logic        req, gnt, rvalid, rerr, if_valid, id_valid, id_err, mtvec_init, busy;
  logic [31:0] addr, rdata, id_pc, id_instr, pc_if;
  step_t       steps [8];
  integer      seed;

  if_stage i_dut (
    .clk (clk), .rst_n (rst_n), .pc_set_i (pc_set), .pc_mux_i (pc_mux),
    .kill_if_i (kill_if), .halt_if_i (halt_if), .boot_addr_i (boot_addr),
    .jump_target_i (jump_target), .branch_target_i (branch_target), .mepc_i (mepc),
    .dm_halt_addr_i (dm_halt_addr), .mtvec_addr_i (mtvec_addr), .irq_id_i (irq_id),
    .instr_req_o (req), .instr_addr_o (addr), .instr_gnt_i (gnt),
    .instr_rvalid_i (rvalid), .instr_rdata_i (rdata), .instr_err_i (rerr),
    .if_valid_o (if_valid), .id_ready_i (id_ready), .id_valid_o (id_valid),
    .id_pc_o (id_pc), .id_instr_o (id_instr), .id_err_o (id_err), .pc_if_o (pc_if),
    .csr_mtvec_init_o (mtvec_init), .if_busy_o (busy)
  );

  tb_instr_mem i_mem (
    .clk (clk), .rst_n (rst_n), .req_i (req), .addr_i (addr), .gnt_o (gnt),
    .rvalid_o (rvalid), .rdata_o (rdata), .err_o (rerr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  // First fetch address by source
  function automatic logic [31:0] target_of(input step_t s);
    case (s.src)
      if_types_pkg::PC_BOOT, if_types_pkg::PC_TRAP_DBD: return s.addr & 32'hffff_fffc;
      if_types_pkg::PC_TRAP_EXC: return {s.mtvec, 7'b0};
      if_types_pkg::PC_TRAP_IRQ: return {s.mtvec, 7'b0} + {25'b0, s.irq, 2'b0};
      default: return s.addr;
    endcase
  endfunction

  task automatic load_steps();
    steps[0] = '{if_types_pkg::PC_BOOT,     32'h0000_1003, 25'h0,    5'd0, 6, 0, 0};
    steps[1] = '{if_types_pkg::PC_JUMP,     32'h0000_2000, 25'h0,    5'd0, 8, 1, 0};
    steps[2] = '{if_types_pkg::PC_BRANCH,   32'h0000_3004, 25'h0,    5'd0, 5, 1, 0};
    steps[3] = '{if_types_pkg::PC_MRET,     32'h0000_4008, 25'h0,    5'd0, 4, 0, 0};
    steps[4] = '{if_types_pkg::PC_TRAP_EXC, 32'h0,         25'h0a0,  5'd3, 3, 1, 0};
    steps[5] = '{if_types_pkg::PC_TRAP_IRQ, 32'h0,         25'h0a0,  5'd7, 4, 0, 0};
    steps[6] = '{if_types_pkg::PC_TRAP_DBD, 32'h0000_6002, 25'h0,    5'd0, 6, 1, 1};
    steps[7] = '{if_types_pkg::PC_JUMP,     32'h0000_fff0, 25'h0,    5'd0, 8, 1, 0};
  endtask

  // Redirect, then consume n instructions and check each one at decode
  task automatic run_step(input step_t s);
    logic [31:0] exp_pc;
    int          issued;
    int          got;
    int          cyc;
    bit          pend;
    exp_pc = target_of(s);
    issued = 0;
    got    = 0;
    cyc    = 0;
    pend   = 0;
    @(posedge clk);
    pc_set        <= 1'b1;
    pc_mux        <= s.src;
    // Unselected target inputs get distinct decoy addresses
    boot_addr     <= 32'h0000_a100;
    jump_target   <= 32'h0000_b200;
    branch_target <= 32'h0000_c300;
    mepc          <= 32'h0000_d400;
    dm_halt_addr  <= 32'h0000_e500;
    case (s.src)
      if_types_pkg::PC_BOOT:     boot_addr     <= s.addr;
      if_types_pkg::PC_JUMP:     jump_target   <= s.addr;
      if_types_pkg::PC_BRANCH:   branch_target <= s.addr;
      if_types_pkg::PC_MRET:     mepc          <= s.addr;
      if_types_pkg::PC_TRAP_DBD: dm_halt_addr  <= s.addr;
      default:                   ;
    endcase
    mtvec_addr    <= s.mtvec;
    irq_id        <= s.irq;
    @(negedge clk);
    check_flag("csr_mtvec_init_o", mtvec_init, s.src == if_types_pkg::PC_BOOT);
    while (got < s.n_instr) begin
      @(posedge clk);
      pc_set   <= 1'b0;
      halt_if  <= s.halt && (cyc < 12);
      id_ready <= (issued < s.n_instr) && (!s.stall || $random(seed) % 3 != 0);
      @(negedge clk);
      cyc++;
      check_flag("csr_mtvec_init_o", mtvec_init, 1'b0);
      if (halt_if) check_flag("if_valid_o", if_valid, 1'b0);
      if (pend) begin
        check_flag("id_valid_o", id_valid, 1'b1);
        check_addr("id_pc_o", id_pc, exp_pc);
        check_word("id_instr_o", id_instr, exp_pc ^ 32'h5a5a_0000);
        check_flag("id_err_o", id_err, (exp_pc >= 32'h0000_f000) && (exp_pc <= 32'h0000_ffff));
        exp_pc += 4;
        got++;
        pend = 0;
      end
      // Buffer head is the next instruction in sequence
      if (if_valid) begin
        check_addr("pc_if_o", pc_if, exp_pc);
      end
      if (if_valid && id_ready) begin
        issued++;
        pend = 1;
      end
      if (cyc > 2000) begin
        $display("timeout: decode received %0d of %0d instructions", got, s.n_instr);
        fail_run();
      end
    end
  endtask

  initial begin
    seed          = 32'h93ab;
    rst_n         = 1'b0;
    pc_set        = 1'b0;
    kill_if       = 1'b0;
    halt_if       = 1'b0;
    id_ready      = 1'b0;
    pc_mux        = if_types_pkg::PC_BOOT;
    boot_addr     = '0;
    jump_target   = '0;
    branch_target = '0;
    mepc          = '0;
    dm_halt_addr  = '0;
    mtvec_addr    = '0;
    irq_id        = '0;
    load_steps();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("instr_req_o", req, 1'b0);
    check_flag("if_valid_o", if_valid, 1'b0);
    check_flag("id_valid_o", id_valid, 1'b0);
    check_flag("csr_mtvec_init_o", mtvec_init, 1'b0);
    check_flag("if_busy_o", busy, 1'b0);
    for (int i = 0; i < 8; i++) begin
      run_step(steps[i]);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
design/if_cfg_pkg.sv
design/if_types_pkg.sv
design/fetch_out_if.sv
design/fetch_fifo.sv
design/pc_mux.sv
design/prefetch_unit.sv
design/if_id_register.sv
design/if_stage.sv
tests/tb_instr_mem.sv
tests/if_stage_sva.sv
tests/tb_if_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_if_stage -o sim_if_stage \
  > build.log 2>&1 \
  && ./obj_dir/sim_if_stage > sim.log 2>&1 \
  || echo "Result: FAILED" >> sim.log

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
